// File: source/tpuPkg.sv
`default_nettype none

package tpuPkg;

    // ==============================
    // Array and memory sizes
    // ==============================
    localparam int ArraySize    = 4;                       // N, PE rows and columns
    localparam int MemDepth     = ArraySize * ArraySize;   // Elements per matrix
    localparam int MemAddrWidth = $clog2(MemDepth);        // Element write address
    localparam int RowAddrWidth = $clog2(ArraySize);       // Row index

    // ==============================
    // Data widths
    // ==============================
    localparam int WeightWidth = 8;                        // Signed weight
    localparam int ActWidth    = 7;                        // Unsigned activation

    // Product plus sign of the unsigned operand plus growth over N terms
    localparam int PsumWidth = WeightWidth + ActWidth + 1 + $clog2(ArraySize);

    // Issue to realigned row, two N-deep sweeps plus the output register
    localparam int ResultLatency = 2 * ArraySize + 1;

    // Element types
    typedef logic signed [WeightWidth-1:0] weightT;
    typedef logic        [ActWidth-1:0]    actT;
    typedef logic signed [PsumWidth-1:0]   psumT;

    // Job sequencer states
    typedef enum logic [1:0] {
        LoadMem,        // Idle, host writes the memories
        PreloadWeight,  // Weights shift down into the array
        Calc,           // Activation rows issued
        Drain           // Wait for the last row to leave the array
    } stateT;

endpackage

`default_nettype wire

// File: source/weightMemory.sv
`timescale 1ns/100ps
`default_nettype none

module weightMemory (
    input  logic                              clk,
    input  logic                              memWriteEn,
    input  logic [tpuPkg::MemAddrWidth-1:0]   weightAddr,
    input  tpuPkg::weightT                    weight,
    input  logic [tpuPkg::RowAddrWidth-1:0]   weightRow,
    output tpuPkg::weightT                    rowWeights [tpuPkg::ArraySize]
);

    // Element k*N + j holds weight[k][j]
    tpuPkg::weightT mem [tpuPkg::MemDepth];

    // Single element writes from the host
    always_ff @(posedge clk) begin
        if (memWriteEn) begin
            mem[weightAddr] <= weight;
        end
    end

    // Whole row read, no register, so the array top edge sees it in the same cycle
    always_comb begin
        for (int j = 0; j < tpuPkg::ArraySize; j++) begin
            rowWeights[j] = mem[int'(weightRow) * tpuPkg::ArraySize + j];  // Column j of row
        end
    end

endmodule

`default_nettype wire

// File: source/activationFeeder.sv
`timescale 1ns/100ps
`default_nettype none

module activationFeeder (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              memWriteEn,
    input  logic [tpuPkg::MemAddrWidth-1:0]   activationAddr,
    input  tpuPkg::actT                       activation,
    input  logic                              actIssue,
    input  logic [tpuPkg::RowAddrWidth-1:0]   actRow,
    output tpuPkg::actT                       leftActs [tpuPkg::ArraySize],
    output logic                              rowValid
);

    // Element r*N + k holds activation[r][k]
    tpuPkg::actT mem [tpuPkg::MemDepth];

    always_ff @(posedge clk) begin
        if (memWriteEn) begin
            mem[activationAddr] <= activation;
        end
    end

    // ==============================
    // Row register and skew bank
    // ==============================
    // Lane k is the row register followed by k skew stages, which gives the
    // 45 degree wavefront on the array's left edge
    for (genvar k = 0; k < tpuPkg::ArraySize; k++) begin : gLane
        tpuPkg::actT pipe [k+1];  // pipe[0] is the row register

        always_ff @(posedge clk) begin
            if (rst) begin
                for (int s = 0; s <= k; s++) begin
                    pipe[s] <= '0;
                end
            end else begin
                // Zero fill between rows keeps idle partial sums at zero
                pipe[0] <= actIssue ? mem[int'(actRow) * tpuPkg::ArraySize + k] : '0;
                for (int s = 1; s <= k; s++) begin
                    pipe[s] <= pipe[s-1];  // One column of skew per stage
                end
            end
        end

        assign leftActs[k] = pipe[k];  // Row k of the array
    end

    // Marks the cycle the row register holds an issued row, unskewed
    always_ff @(posedge clk) begin
        if (rst) begin
            rowValid <= 1'b0;
        end else begin
            rowValid <= actIssue;
        end
    end

    // A job issues N rows, so a longer burst means the sequencer overran Calc
    assert property (@(posedge clk) disable iff (rst)
        rowValid [*tpuPkg::ArraySize] |=> !rowValid)
        else $error("rowValid high for more than ArraySize cycles");

endmodule

`default_nettype wire

// File: source/tpuController.sv
`timescale 1ns/100ps
`default_nettype none

module tpuController (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              start,
    input  logic                              memWrite,
    output logic                              memWriteEn,
    output logic                              weightLoad,
    output logic                              actIssue,
    output logic                              busy,
    output logic                              done,
    output logic [tpuPkg::RowAddrWidth-1:0]   weightRow,
    output logic [tpuPkg::RowAddrWidth-1:0]   actRow
);

    // Wide enough for the longest phase, which is Drain
    typedef logic [$clog2(tpuPkg::ResultLatency)-1:0] countT;

    tpuPkg::stateT state;
    countT         cycleCnt;  // Cycle within the current phase
    logic          idle;      // Ready for writes and a new start

    // ==============================
    // Decoded outputs
    // ==============================
    // The done cycle already sits in LoadMem but still counts as busy
    assign idle       = (state == tpuPkg::LoadMem) && !done;
    assign busy       = !idle;
    assign memWriteEn = memWrite && idle;                   // Host writes only when idle
    assign weightLoad = (state == tpuPkg::PreloadWeight);
    assign actIssue   = (state == tpuPkg::Calc);

    // Preload reads the last weight row first so row 0 ends at the top
    assign weightRow = tpuPkg::RowAddrWidth'(tpuPkg::ArraySize - 1)
                     - cycleCnt[tpuPkg::RowAddrWidth-1:0];
    assign actRow    = cycleCnt[tpuPkg::RowAddrWidth-1:0];  // Rows in order 0..N-1

    // ==============================
    // Job sequencer
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= tpuPkg::LoadMem;
            cycleCnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;  // Single cycle pulse
            case (state)
                tpuPkg::LoadMem: begin
                    if (start && !done) begin  // start during done is still busy
                        state    <= tpuPkg::PreloadWeight;
                        cycleCnt <= '0;
                    end
                end
                tpuPkg::PreloadWeight: begin
                    if (cycleCnt == countT'(tpuPkg::ArraySize - 1)) begin
                        state    <= tpuPkg::Calc;
                        cycleCnt <= '0;
                    end else begin
                        cycleCnt <= cycleCnt + 1'b1;
                    end
                end
                tpuPkg::Calc: begin
                    if (cycleCnt == countT'(tpuPkg::ArraySize - 1)) begin
                        state    <= tpuPkg::Drain;
                        cycleCnt <= '0;
                    end else begin
                        cycleCnt <= cycleCnt + 1'b1;
                    end
                end
                tpuPkg::Drain: begin
                    // Last result row is on the output in the final Drain cycle
                    if (cycleCnt == countT'(tpuPkg::ResultLatency - 1)) begin
                        state    <= tpuPkg::LoadMem;
                        cycleCnt <= '0;
                        done     <= 1'b1;
                    end else begin
                        cycleCnt <= cycleCnt + 1'b1;
                    end
                end
                default: state <= tpuPkg::LoadMem;
            endcase
        end
    end

    // Preload hands over to Calc after exactly N cycles and never overlaps it
    assert property (@(posedge clk) disable iff (rst)
        $rose(weightLoad) |-> (weightLoad && !actIssue) [*tpuPkg::ArraySize]
            ##1 (actIssue && !weightLoad) [*tpuPkg::ArraySize] ##1 !actIssue)
        else $error("weightLoad and actIssue overlap or a phase has the wrong length");

endmodule

`default_nettype wire

// File: source/processingElement.sv
`timescale 1ns/100ps
`default_nettype none

module processingElement (
    input  logic           clk,
    input  logic           rst,
    input  logic           weightLoad,
    input  tpuPkg::weightT weightIn,
    output tpuPkg::weightT weightOut,
    input  tpuPkg::actT    actIn,
    output tpuPkg::actT    actOut,
    input  tpuPkg::psumT   psumIn,
    output tpuPkg::psumT   psumOut
);

    logic signed [tpuPkg::ActWidth:0] actSigned;  // Activation with a zero sign bit
    tpuPkg::psumT                     product;

    // Both operands signed so the weight sign extends correctly
    assign actSigned = {1'b0, actIn};
    assign product   = tpuPkg::psumT'(weightOut) * tpuPkg::psumT'(actSigned);

    always_ff @(posedge clk) begin
        if (rst) begin
            weightOut <= '0;
            actOut    <= '0;
            psumOut   <= '0;
        end else begin
            if (weightLoad) begin
                weightOut <= weightIn;  // Shift down, held otherwise
            end
            actOut  <= actIn;             // On to the next column
            psumOut <= psumIn + product;  // On to the next row
        end
    end

endmodule

`default_nettype wire

// File: source/systolicArray.sv
`timescale 1ns/100ps
`default_nettype none

module systolicArray (
    input  logic           clk,
    input  logic           rst,
    input  logic           weightLoad,
    input  tpuPkg::weightT topWeights [tpuPkg::ArraySize],
    input  tpuPkg::actT    leftActs   [tpuPkg::ArraySize],
    output tpuPkg::psumT   bottomSums [tpuPkg::ArraySize]
);

    localparam int N = tpuPkg::ArraySize;

    // Grid wiring, one extra row or column for the far edge
    tpuPkg::weightT weightW [N+1][N];  // Downward weights
    tpuPkg::actT    actW    [N][N+1];  // Rightward activations
    tpuPkg::psumT   psumW   [N+1][N];  // Downward partial sums

    // Edge connections
    for (genvar e = 0; e < N; e++) begin : gEdge
        assign weightW[0][e] = topWeights[e];
        assign actW[e][0]    = leftActs[e];
        assign psumW[0][e]   = '0;              // Columns start from zero
        assign bottomSums[e] = psumW[N][e];
    end

    // ==============================
    // PE grid, row i and column j
    // ==============================
    for (genvar i = 0; i < N; i++) begin : gRow
        for (genvar j = 0; j < N; j++) begin : gCol
            processingElement u_pe (
                .clk        (clk),
                .rst        (rst),
                .weightLoad (weightLoad),
                .weightIn   (weightW[i][j]),
                .weightOut  (weightW[i+1][j]),
                .actIn      (actW[i][j]),
                .actOut     (actW[i][j+1]),
                .psumIn     (psumW[i][j]),
                .psumOut    (psumW[i+1][j])
            );
        end
    end

endmodule

`default_nettype wire

// File: source/outputDeskew.sv
`timescale 1ns/100ps
`default_nettype none

module outputDeskew (
    input  logic         clk,
    input  logic         rst,
    input  tpuPkg::psumT bottomSums [tpuPkg::ArraySize],
    input  logic         rowValid,
    output tpuPkg::psumT result     [tpuPkg::ArraySize],
    output logic         resultValid
);

    localparam int N = tpuPkg::ArraySize;

    // Column j leaves the array j cycles after column 0, so it gets
    // N-1-j deskew stages plus the shared output register
    for (genvar j = 0; j < N; j++) begin : gCol
        tpuPkg::psumT pipe [N-j];

        always_ff @(posedge clk) begin
            pipe[0] <= bottomSums[j];
            for (int s = 1; s < N - j; s++) begin
                pipe[s] <= pipe[s-1];
            end
        end

        assign result[j] = pipe[N-j-1];  // Last stage is the output register
    end

    // ==============================
    // Valid delay line
    // ==============================
    // rowValid is one cycle after issue, so the rest of the latency is here
    logic [tpuPkg::ResultLatency-2:0] validPipe;

    always_ff @(posedge clk) begin
        if (rst) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[tpuPkg::ResultLatency-3:0], rowValid};
        end
    end

    assign resultValid = validPipe[tpuPkg::ResultLatency-2];

    // One job yields N rows, a longer run means rows from two jobs merged
    assert property (@(posedge clk) disable iff (rst)
        resultValid [*N] |=> !resultValid)
        else $error("resultValid high for more than ArraySize cycles");

endmodule

`default_nettype wire

// File: source/tpuCore.sv
`timescale 1ns/100ps
`default_nettype none

module tpuCore (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              memWrite,
    input  tpuPkg::weightT                    weight,
    input  logic [tpuPkg::MemAddrWidth-1:0]   weightAddr,
    input  tpuPkg::actT                       activation,
    input  logic [tpuPkg::MemAddrWidth-1:0]   activationAddr,
    input  logic                              start,
    output logic                              busy,
    output tpuPkg::psumT                      result [tpuPkg::ArraySize],
    output logic                              resultValid,
    output logic                              done
);

    logic                            memWriteEn;   // Host write, idle only
    logic                            weightLoad;
    logic                            actIssue;
    logic [tpuPkg::RowAddrWidth-1:0] weightRow;
    logic [tpuPkg::RowAddrWidth-1:0] actRow;
    logic                            rowValid;     // Unskewed issue marker
    tpuPkg::weightT                  rowWeights [tpuPkg::ArraySize];
    tpuPkg::actT                     leftActs   [tpuPkg::ArraySize];
    tpuPkg::psumT                    bottomSums [tpuPkg::ArraySize];

    tpuController u_ctrl (
        .clk(clk), .rst(rst), .start(start), .memWrite(memWrite),
        .memWriteEn(memWriteEn), .weightLoad(weightLoad), .actIssue(actIssue),
        .busy(busy), .done(done), .weightRow(weightRow), .actRow(actRow)
    );

    weightMemory u_wmem (
        .clk(clk), .memWriteEn(memWriteEn), .weightAddr(weightAddr),
        .weight(weight), .weightRow(weightRow), .rowWeights(rowWeights)
    );

    activationFeeder u_feed (
        .clk(clk), .rst(rst), .memWriteEn(memWriteEn), .activationAddr(activationAddr),
        .activation(activation), .actIssue(actIssue), .actRow(actRow),
        .leftActs(leftActs), .rowValid(rowValid)
    );

    systolicArray u_array (
        .clk(clk), .rst(rst), .weightLoad(weightLoad), .topWeights(rowWeights),
        .leftActs(leftActs), .bottomSums(bottomSums)
    );

    outputDeskew u_deskew (
        .clk(clk), .rst(rst), .bottomSums(bottomSums), .rowValid(rowValid),
        .result(result), .resultValid(resultValid)
    );

endmodule

`default_nettype wire

// File: tests/tpuCheck.svh
`ifndef TPU_CHECK_SVH
`define TPU_CHECK_SVH

// ==============================
// Counters and random source
// ==============================
int          errorCount = 0;          // Failed checks over the whole run
bit          timedOut   = 1'b0;       // Set once any wait gives up
logic [31:0] rngState   = 32'd55911;  // xorshift state

// One 32-bit xorshift step
function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
endfunction

function automatic logic [31:0] nextRandom();
    rngState = xorshift(rngState);
    return rngState;
endfunction

// ==============================
// Compare tasks
// ==============================
task automatic checkPsum(input string what, input tpuPkg::psumT got, input tpuPkg::psumT exp);
    if (got !== exp) begin
        errorCount++;
        $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
endtask

task automatic checkFlag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
        errorCount++;
        $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

// Polls resultValid on falling edges, gives up after limit cycles
task automatic waitForResult(input int limit, output bit seen);
    seen = 1'b0;
    for (int c = 0; c < limit && !seen; c++) begin
        @(negedge clk);
        seen = (resultValid === 1'b1);
    end
    if (!seen) begin
        timedOut = 1'b1;
        $display("Timeout: no result row appeared within %0d cycles", limit);
    end
endtask

`endif

// File: tests/tpuCoreTb.sv
`timescale 1ns/100ps
`default_nettype none

module tpuCoreTb;

    localparam int N         = tpuPkg::ArraySize;
    localparam int AW        = tpuPkg::MemAddrWidth;
    localparam int NumJobs   = 6;
    localparam int WaitLimit = 100;                                 // Cycles per wait
    localparam int RowZeroAt = 1 + N + tpuPkg::ResultLatency;       // start cycle to row 0

    typedef enum {JobIdentity, JobRandom, JobExtreme, JobBusyPoke, JobReuse} jobKindT;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 memWrite;
    tpuPkg::weightT       weight;
    logic [AW-1:0]        weightAddr;
    tpuPkg::actT          activation;
    logic [AW-1:0]        activationAddr;
    logic                 start;
    logic                 busy;
    tpuPkg::psumT         result [N];
    logic                 resultValid;
    logic                 done;
    int                   cycleNum = 0;  // Rising edges since time zero

    // ==============================
    // Job table
    // ==============================
    jobKindT        kindTab   [NumJobs];
    bit             reuseTab  [NumJobs];        // Start only, memories kept
    tpuPkg::weightT weightTab [NumJobs][N][N];  // [k][j]
    tpuPkg::actT    actTab    [NumJobs][N][N];  // [r][k]
    tpuPkg::psumT   expTab    [NumJobs][N][N];  // [r][j]

    `include "tpuCheck.svh"

    always #5 clk = ~clk;                       // 10 ns period

    always @(posedge clk) cycleNum <= cycleNum + 1;

    tpuCore i_dut (
        .clk(clk), .rst(rst), .memWrite(memWrite), .weight(weight), .weightAddr(weightAddr),
        .activation(activation), .activationAddr(activationAddr), .start(start),
        .busy(busy), .result(result), .resultValid(resultValid), .done(done)
    );

    // Sum over k of act[r][k] times weight[k][j], exact in int
    function automatic tpuPkg::psumT expectedSum(input int t, input int r, input int j);
        int acc;
        acc = 0;
        for (int k = 0; k < N; k++) begin
            acc += int'(weightTab[t][k][j]) * int'(actTab[t][r][k]);
        end
        return tpuPkg::psumT'(acc);
    endfunction

    task automatic buildTable();
        logic [31:0] rnd;
        kindTab = '{JobIdentity, JobRandom, JobExtreme, JobBusyPoke, JobReuse, JobRandom};
        for (int t = 0; t < NumJobs; t++) begin
            reuseTab[t] = (kindTab[t] == JobReuse);
            for (int a = 0; a < N; a++) begin
                for (int b = 0; b < N; b++) begin
                    rnd = nextRandom();
                    weightTab[t][a][b] = rnd[15:8];
                    actTab[t][a][b]    = rnd[6:0];
                    case (kindTab[t])
                        JobIdentity: weightTab[t][a][b] = (a == b) ? 8'sd1 : 8'sd0;
                        JobExtreme: begin
                            // Column 0 all -128, column 1 all 127, rest a checkerboard
                            if (b == 0 || (b > 1 && (a + b) % 2 == 0)) begin
                                weightTab[t][a][b] = 8'sh80;
                            end else begin
                                weightTab[t][a][b] = 8'sh7F;
                            end
                            if (a < N - 1) actTab[t][a][b] = 7'h7F;  // Last row stays random
                        end
                        JobReuse: begin
                            weightTab[t][a][b] = weightTab[t-1][a][b];  // Matrices of job before
                            actTab[t][a][b]    = actTab[t-1][a][b];
                        end
                        default: ;
                    endcase
                end
            end
        end
        for (int t = 0; t < NumJobs; t++) begin
            for (int r = 0; r < N; r++) begin
                for (int j = 0; j < N; j++) begin
                    expTab[t][r][j] = expectedSum(t, r, j);
                end
            end
        end
    endtask

    // One element of each matrix per cycle, same linear address
    task automatic writeMemories(input int t);
        for (int e = 0; e < tpuPkg::MemDepth; e++) begin
            @(posedge clk);
            memWrite       <= 1'b1;
            weightAddr     <= AW'(e);
            weight         <= weightTab[t][e / N][e % N];  // k*N + j
            activationAddr <= AW'(e);
            activation     <= actTab[t][e / N][e % N];     // r*N + k
        end
        @(posedge clk);
        memWrite <= 1'b0;
    endtask

    // Writes and starts during a job, none of which may land
    task automatic pokeWhileBusy(input int t);
        for (int i = 0; i < N; i++) begin
            @(posedge clk);
            memWrite       <= 1'b1;
            start          <= 1'b1;
            weightAddr     <= AW'(i);
            weight         <= ~weightTab[t][0][i];  // Always differs from stored row 0
            activationAddr <= AW'(i);
            activation     <= ~actTab[t][0][i];
        end
        @(posedge clk);
        memWrite <= 1'b0;
        start    <= 1'b0;
    endtask

    task automatic checkIdle(output bit ok);
        int errorsBefore;
        errorsBefore = errorCount;
        repeat (20) begin
            @(negedge clk);
            checkFlag("busy while idle", busy, 1'b0);
            checkFlag("resultValid while idle", resultValid, 1'b0);
            checkFlag("done while idle", done, 1'b0);
        end
        ok = (errorCount == errorsBefore);
        $display("Test 0 idle after reset: %s", ok ? "passed" : "failed");
    endtask

    task automatic runJob(input int t, output bit ok);
        int startCycle;
        int errorsBefore;
        bit seen;
        errorsBefore = errorCount;
        if (!reuseTab[t]) begin
            writeMemories(t);
        end
        @(posedge clk);
        start <= 1'b1;
        @(negedge clk);
        startCycle = cycleNum;  // Cycle in which start is high
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        checkFlag("busy after start", busy, 1'b1);
        if (kindTab[t] == JobBusyPoke) begin
            pokeWhileBusy(t);
        end
        waitForResult(WaitLimit, seen);
        if (seen) begin
            checkFlag($sformatf("row 0 at cycle %0d after start", cycleNum - startCycle),
                      (cycleNum - startCycle) == RowZeroAt, 1'b1);
            for (int r = 0; r < N; r++) begin
                if (r > 0) begin
                    @(negedge clk);  // Rows come back to back
                    checkFlag($sformatf("resultValid for row %0d", r), resultValid, 1'b1);
                end
                for (int j = 0; j < N; j++) begin
                    checkPsum($sformatf("job %0d row %0d column %0d", t + 1, r, j),
                              result[j], expTab[t][r][j]);
                end
            end
            @(negedge clk);
            checkFlag("resultValid after last row", resultValid, 1'b0);
            checkFlag("done after last row", done, 1'b1);
            checkFlag("busy in done cycle", busy, 1'b1);
            @(negedge clk);
            checkFlag("done one cycle later", done, 1'b0);  // Single pulse
            checkFlag("busy after done", busy, 1'b0);
        end
        ok = seen && (errorCount == errorsBefore);
        $display("Test %0d %s: %s", t + 1, kindTab[t].name(), ok ? "passed" : "failed");
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        int failedTests;
        int testsRun;
        bit ok;
        failedTests    = 0;
        rst            = 1'b1;
        memWrite       = 1'b0;
        weight         = '0;
        weightAddr     = '0;
        activation     = '0;
        activationAddr = '0;
        start          = 1'b0;
        buildTable();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        checkIdle(ok);
        testsRun = 1;
        failedTests += ok ? 0 : 1;
        for (int t = 0; t < NumJobs && !timedOut; t++) begin
            runJob(t, ok);
            testsRun++;
            failedTests += ok ? 0 : 1;
        end
        $display("Tests run %0d, failed %0d, check errors %0d", testsRun, failedTests,
                 errorCount);
        if (errorCount == 0 && failedTests == 0 && !timedOut) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+tests
source/tpuPkg.sv
source/weightMemory.sv
source/activationFeeder.sv
source/tpuController.sv
source/processingElement.sv
source/systolicArray.sv
source/outputDeskew.sv
source/tpuCore.sv
tests/tpuCoreTb.sv

// File: Bender.yml
package:
  name: tpu_core

sources:
  - source/tpuPkg.sv
  - source/weightMemory.sv
  - source/activationFeeder.sv
  - source/tpuController.sv
  - source/processingElement.sv
  - source/systolicArray.sv
  - source/outputDeskew.sv
  - source/tpuCore.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tpuCoreTb.sv
